// File: dv/thiele_tests.txt
# instr    delay value    status   error    cert     info     part_ops
# delay is the ack wait in cycles (decimal), every other column is hex
0D000000 0 00000000 00000002 00000000 00000000 00000000 00000000
0C000100 0 00000000 00000009 00000000 00000000 00000000 00000001
0D000000 0 00000000 00000002 00000000 00000000 00000000 00000001
0C000100 0 00000000 00000009 00000000 00000000 00000000 00000002
0B000300 0 00000000 00000008 00000000 00000000 00000000 00000003
0D000000 0 00000000 00000001 00000000 00000000 00000000 00000003
0A057F00 0 00000000 00000001 0000000C 00000000 00000000 00000003
0B000400 0 00000000 00000001 0000000A 00000000 00000000 00000003
0D000000 0 00000000 00000001 0000000A 00000000 00000000 00000003
0A024100 0 00000000 00000007 0000000A 00000000 00000000 00000003
0D000000 0 00000000 00000002 0000000A 00000000 00000000 00000003
0C010600 0 00000000 00000002 0000000B 00000000 00000000 00000003
03123400 0 CAFE0001 00000002 0000000B CAFE0001 00000000 00000003
03BEEF00 5 0BADF00D 00000002 0000000B 0BADF00D 00000000 00000003
08004200 3 00000777 00000777 0000000B 0BADF00D 00000000 00000003
0E002A00 0 00000000 002A0000 0000000B 0BADF00D 0000002A 00000003
0E031100 0 00000000 03110000 0000000B 0BADF00D 0000002B 00000003
045AC300 0 00000000 00000004 0000000B 5AC30000 0000002B 00000003
77000000 0 00000000 00000004 00000001 5AC30000 0000002B 00000003
FF000000 0 00000000 00000004 00000001 5AC30000 0000002B 00000003

// File: verilog.f
+incdir+rtl
rtl/thiele_pkg.sv
rtl/gf2_matrix_unit.sv
rtl/service_handshake.sv
rtl/thiele_control.sv
rtl/thiele_cpu.sv
dv/thiele_cpu_asserts.sv
dv/thiele_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= thiele_cpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/thiele_cpu_tb.sv
`timescale 1ns/10ps

`include "thiele_cfg.svh"

module thiele_cpu_tb;

    import thiele_pkg::*;

    localparam int    MAX_LINES    = 64;
    localparam int    RESET_CYCLES = 10;
    localparam int    HOLD_CYCLES  = 4;
    localparam string TEST_FILE    = "dv/thiele_tests.txt";

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_data;
    logic [31:0] pc;
    logic [31:0] cert_addr;
    logic [31:0] status;
    logic [31:0] error_code;
    logic [31:0] partition_ops;
    logic [31:0] info_gain;
    logic        halted;
    logic        logic_req;
    logic [31:0] logic_addr;
    logic        logic_ack;
    logic [31:0] logic_data;
    logic        py_req;
    logic [31:0] py_code_addr;
    logic        py_ack;
    logic [31:0] py_result;

    // One entry per line of the test file
    logic [31:0] instr_tab  [MAX_LINES];
    int          delay_tab  [MAX_LINES];
    logic [31:0] value_tab  [MAX_LINES];
    logic [31:0] exp_status [MAX_LINES];
    logic [31:0] exp_error  [MAX_LINES];
    logic [31:0] exp_cert   [MAX_LINES];
    logic [31:0] exp_info   [MAX_LINES];
    logic [31:0] exp_pops   [MAX_LINES];
    int          num_lines;
    int          max_delay;

    int          pass_count;
    int          fail_count;
    int          error_count;
    int          addr_errors;
    int          cycle_count;
    int          cycle_limit;
    int          logic_wait;
    int          py_wait;
    bit          running;
    bit          halt_seen;
    bit          timed_out;
    bit          overrun;
    logic [31:0] last_pc;
    logic [31:0] halt_pc;

    thiele_cpu thiele_cpu_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_data    (instr_data),
        .pc            (pc),
        .cert_addr     (cert_addr),
        .status        (status),
        .error_code    (error_code),
        .partition_ops (partition_ops),
        .info_gain     (info_gain),
        .halted        (halted),
        .logic_req     (logic_req),
        .logic_addr    (logic_addr),
        .logic_ack     (logic_ack),
        .logic_data    (logic_data),
        .py_req        (py_req),
        .py_code_addr  (py_code_addr),
        .py_ack        (py_ack),
        .py_result     (py_result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic int line_index();
        return int'(pc / `THIELE_PC_STEP);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, inout int errs);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errs++;
        end
    endtask

    // ========================================================================
    // Test file
    // ========================================================================

    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] word;
        int          delay;
        logic [31:0] value;
        logic [31:0] st;
        logic [31:0] er;
        logic [31:0] ca;
        logic [31:0] ig;
        logic [31:0] po;
        num_lines = 0;
        max_delay = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test file %s", TEST_FILE);
            error_count++;
        end else begin
            // Comment lines fail the first hex field and are skipped
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %d %h %h %h %h %h %h",
                            word, delay, value, st, er, ca, ig, po);
                if (n == 8 && num_lines < MAX_LINES) begin
                    instr_tab[num_lines]  = word;
                    delay_tab[num_lines]  = delay;
                    value_tab[num_lines]  = value;
                    exp_status[num_lines] = st;
                    exp_error[num_lines]  = er;
                    exp_cert[num_lines]   = ca;
                    exp_info[num_lines]   = ig;
                    exp_pops[num_lines]   = po;
                    if (delay > max_delay) begin
                        max_delay = delay;
                    end
                    num_lines++;
                end else if (n > 0) begin
                    $display("Malformed or excess test line: %s", line);
                    error_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Instruction feed and service engines
    // ========================================================================

    task automatic drive_instruction();
        if (line_index() < num_lines) begin
            instr_data = instr_tab[line_index()];
        end else begin
            // Beyond the last line the core is fed HALT
            instr_data = {OP_HALT, 24'h0};
        end
    endtask

    // Ack rises after the line's delay and is held that long again once req falls
    task automatic answer_services();
        int idx;
        idx = line_index();
        if (idx >= num_lines) begin
            idx = num_lines - 1;
        end
        if (logic_req && !logic_ack) begin
            if (logic_wait >= delay_tab[idx]) begin
                compare_value("logic_addr", {16'h0, instr_tab[idx][23:8]}, logic_addr,
                              addr_errors);
                logic_data = value_tab[idx];
                logic_ack  = 1'b1;
                logic_wait = 0;
            end else begin
                logic_wait++;
            end
        end else if (!logic_req && logic_ack) begin
            if (logic_wait >= delay_tab[idx]) begin
                logic_ack  = 1'b0;
                logic_data = '0;
                logic_wait = 0;
            end else begin
                logic_wait++;
            end
        end
        if (py_req && !py_ack) begin
            if (py_wait >= delay_tab[idx]) begin
                compare_value("py_code_addr", {16'h0, instr_tab[idx][23:8]}, py_code_addr,
                              addr_errors);
                py_result = value_tab[idx];
                py_ack    = 1'b1;
                py_wait   = 0;
            end else begin
                py_wait++;
            end
        end else if (!py_req && py_ack) begin
            if (py_wait >= delay_tab[idx]) begin
                py_ack    = 1'b0;
                py_result = '0;
                py_wait   = 0;
            end else begin
                py_wait++;
            end
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic check_test(input int idx, input logic [31:0] expected_pc);
        int errs;
        errs        = addr_errors;
        addr_errors = 0;
        compare_value("pc", expected_pc, pc, errs);
        compare_value("status", exp_status[idx], status, errs);
        compare_value("error_code", exp_error[idx], error_code, errs);
        compare_value("cert_addr", exp_cert[idx], cert_addr, errs);
        compare_value("info_gain", exp_info[idx], info_gain, errs);
        compare_value("partition_ops", exp_pops[idx], partition_ops, errs);
        error_count += errs;
        if (errs == 0) begin
            pass_count++;
            $display("Test %0d instr %h: pass", idx, instr_tab[idx]);
        end else begin
            fail_count++;
            $display("Test %0d instr %h: FAIL with %0d errors", idx, instr_tab[idx], errs);
        end
    endtask

    task automatic track_progress();
        int idx;
        idx = int'(last_pc / `THIELE_PC_STEP);
        if (pc !== last_pc) begin
            if (idx < num_lines) begin
                check_test(idx, last_pc + `THIELE_PC_STEP);
            end
            last_pc = pc;
            if (!overrun) begin
                assert (line_index() < num_lines) else begin
                    $display("pc ran past the last test line at time %0t", $time);
                    error_count++;
                    overrun = 1'b1;
                end
            end
        end else if (halted) begin
            halt_seen = 1'b1;
            halt_pc   = pc;
            if (idx < num_lines) begin
                assert (instr_tab[idx][31:24] == OP_HALT) else begin
                    $display("halted was raised on line %0d, which is not a HALT", idx);
                    error_count++;
                end
                check_test(idx, last_pc);
            end
        end
    endtask

    // pc and halted must stay frozen after HALT
    task check_halt_hold();
        int errs;
        errs = 0;
        repeat (HOLD_CYCLES) @(negedge clk);
        compare_value("pc", halt_pc, pc, errs);
        assert (halted === 1'b1) else begin
            $display("halted dropped after HALT at time %0t", $time);
            errs++;
        end
        error_count += errs;
    endtask

    always @(negedge clk) begin
        if (running && !halt_seen && !timed_out) begin
            cycle_count++;
            drive_instruction();
            answer_services();
            track_progress();
            if (cycle_count >= cycle_limit && !halt_seen) begin
                timed_out = 1'b1;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_data  = '0;
        logic_ack   = 1'b0;
        logic_data  = '0;
        py_ack      = 1'b0;
        py_result   = '0;
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
        addr_errors = 0;
        cycle_count = 0;
        cycle_limit = 0;
        logic_wait  = 0;
        py_wait     = 0;
        running     = 1'b0;
        halt_seen   = 1'b0;
        timed_out   = 1'b0;
        overrun     = 1'b0;
        last_pc     = '0;
        halt_pc     = '0;
        read_tests();
        if (num_lines == 0) begin
            $display("No usable test lines in %s", TEST_FILE);
            error_count++;
        end else begin
            cycle_limit = num_lines * (8 + max_delay);
            instr_data  = instr_tab[0];
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n   = 1'b1;
            running = 1'b1;
            wait (halt_seen || timed_out);
            if (timed_out) begin
                $display("Timeout: HALT not reached within %0d cycles", cycle_limit);
                error_count++;
            end else begin
                check_halt_hold();
            end
        end
        error_count += thiele_cpu_inst.asserts_inst.failures;
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: dv/thiele_cpu_asserts.sv
`timescale 1ns/10ps

module thiele_cpu_asserts (
    input logic clk,
    input logic rst_n,
    input logic halted,
    input logic logic_req,
    input logic logic_ack,
    input logic py_req,
    input logic py_ack
);

    int failures = 0;

    // Requests hold until acknowledged
    logic_req_held: assert property (
        @(posedge clk) disable iff (!rst_n) logic_req && !logic_ack |=> logic_req
    ) else begin
        $error("logic_req dropped before logic_ack");
        failures++;
    end

    py_req_held: assert property (
        @(posedge clk) disable iff (!rst_n) py_req && !py_ack |=> py_req
    ) else begin
        $error("py_req dropped before py_ack");
        failures++;
    end

    // No new request while the previous ack is still up
    logic_req_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) !logic_req && logic_ack |=> !logic_req
    ) else begin
        $error("logic_req rose while logic_ack was high");
        failures++;
    end

    py_req_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) !py_req && py_ack |=> !py_req
    ) else begin
        $error("py_req rose while py_ack was high");
        failures++;
    end

    one_service: assert property (
        @(posedge clk) disable iff (!rst_n) !(logic_req && py_req)
    ) else begin
        $error("logic_req and py_req high together");
        failures++;
    end

    halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else begin
        $error("halted dropped after being set");
        failures++;
    end

endmodule

bind thiele_cpu thiele_cpu_asserts asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .halted    (halted),
    .logic_req (logic_req),
    .logic_ack (logic_ack),
    .py_req    (py_req),
    .py_ack    (py_ack)
);

// File: rtl/thiele_cpu.sv
`timescale 1ns/10ps

`include "thiele_cfg.svh"

module thiele_cpu (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr_data,
    output logic [31:0] pc,
    output logic [31:0] cert_addr,
    output logic [31:0] status,
    output logic [31:0] error_code,
    output logic [31:0] partition_ops,
    output logic [31:0] info_gain,
    output logic        halted,
    output logic        logic_req,
    output logic [31:0] logic_addr,
    input  logic        logic_ack,
    input  logic [31:0] logic_data,
    output logic        py_req,
    output logic [31:0] py_code_addr,
    input  logic        py_ack,
    input  logic [31:0] py_result
);

    import thiele_pkg::*;

    localparam int ROW_W = $clog2(`THIELE_XOR_ROWS);

    // Controller to matrix unit
    gf2_op_t                    gf2_op;
    logic [ROW_W-1:0]           row_a;
    logic [ROW_W-1:0]           row_b;
    logic                       row_a_ovf;
    logic                       row_b_ovf;
    logic [`THIELE_XOR_COLS:0]  load_bits;
    logic                       row_ok;
    logic [ROW_W:0]             lead_count;

    // Controller to service ports
    logic        logic_start;
    logic        exec_start;
    logic [15:0] service_addr;
    logic        logic_done;
    logic        exec_done;
    logic [31:0] logic_result;
    logic [31:0] exec_result;

    thiele_control control_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_data    (instr_data),
        .pc            (pc),
        .cert_addr     (cert_addr),
        .status        (status),
        .error_code    (error_code),
        .partition_ops (partition_ops),
        .info_gain     (info_gain),
        .halted        (halted),
        .gf2_op        (gf2_op),
        .row_a         (row_a),
        .row_b         (row_b),
        .row_a_ovf     (row_a_ovf),
        .row_b_ovf     (row_b_ovf),
        .load_bits     (load_bits),
        .row_ok        (row_ok),
        .lead_count    (lead_count),
        .logic_start   (logic_start),
        .exec_start    (exec_start),
        .service_addr  (service_addr),
        .logic_done    (logic_done),
        .exec_done     (exec_done),
        .logic_result  (logic_result),
        .exec_result   (exec_result)
    );

    gf2_matrix_unit matrix_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gf2_op     (gf2_op),
        .row_a      (row_a),
        .row_b      (row_b),
        .row_a_ovf  (row_a_ovf),
        .row_b_ovf  (row_b_ovf),
        .load_bits  (load_bits),
        .row_ok     (row_ok),
        .lead_count (lead_count)
    );

    // Logic engine port, LASSERT
    service_handshake logic_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (logic_start),
        .addr     (service_addr),
        .req      (logic_req),
        .req_addr (logic_addr),
        .ack      (logic_ack),
        .data     (logic_data),
        .done     (logic_done),
        .result   (logic_result)
    );

    // External code execution port, PYEXEC
    service_handshake exec_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (exec_start),
        .addr     (service_addr),
        .req      (py_req),
        .req_addr (py_code_addr),
        .ack      (py_ack),
        .data     (py_result),
        .done     (exec_done),
        .result   (exec_result)
    );

endmodule

// File: rtl/thiele_control.sv
`timescale 1ns/10ps

`include "thiele_cfg.svh"

module thiele_control (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [31:0]                           instr_data,
    output logic [31:0]                           pc,
    output logic [31:0]                           cert_addr,
    output logic [31:0]                           status,
    output logic [31:0]                           error_code,
    output logic [31:0]                           partition_ops,
    output logic [31:0]                           info_gain,
    output logic                                  halted,
    output thiele_pkg::gf2_op_t                   gf2_op,
    output logic [$clog2(`THIELE_XOR_ROWS)-1:0]   row_a,
    output logic [$clog2(`THIELE_XOR_ROWS)-1:0]   row_b,
    output logic                                  row_a_ovf,
    output logic                                  row_b_ovf,
    output logic [`THIELE_XOR_COLS:0]             load_bits,
    input  logic                                  row_ok,
    input  logic [$clog2(`THIELE_XOR_ROWS):0]     lead_count,
    output logic                                  logic_start,
    output logic                                  exec_start,
    output logic [15:0]                           service_addr,
    input  logic                                  logic_done,
    input  logic                                  exec_done,
    input  logic [31:0]                           logic_result,
    input  logic [31:0]                           exec_result
);

    import thiele_pkg::*;

    localparam int ROW_W = $clog2(`THIELE_XOR_ROWS);

    ctrl_state_t state;
    instr_u      ir;
    logic [31:0] next_pc;

    assign next_pc = pc + `THIELE_PC_STEP;

    // Instruction word held from fetch through execute
    always_ff @(posedge clk) begin
        if (state == S_FETCH) begin
            ir <= instr_data;
        end
    end

    // ========================================================================
    // Requests to the matrix unit and service ports, execute cycle only
    // ========================================================================

    always_comb begin
        gf2_op = GF2_NONE;
        if (state == S_EXECUTE) begin
            case (ir.f.opcode)
                OP_XOR_LOAD: gf2_op = GF2_LOAD;
                OP_XOR_ADD:  gf2_op = GF2_ADD;
                OP_XOR_SWAP: gf2_op = GF2_SWAP;
                OP_XOR_RANK: gf2_op = GF2_COUNT;
                default:     gf2_op = GF2_NONE;
            endcase
        end
    end

    assign row_a     = ir.f.operand_a[ROW_W-1:0];
    assign row_b     = ir.f.operand_b[ROW_W-1:0];
    assign row_a_ovf = |ir.f.operand_a[7:ROW_W];
    assign row_b_ovf = |ir.f.operand_b[7:ROW_W];
    // Load data sits in operand_b, parity in its top used bit
    assign load_bits = ir.f.operand_b[`THIELE_XOR_COLS:0];

    assign logic_start  = (state == S_EXECUTE) && (ir.f.opcode == OP_LASSERT);
    assign exec_start   = (state == S_EXECUTE) && (ir.f.opcode == OP_PYEXEC);
    assign service_addr = ir.i.imm;
    assign halted       = (state == S_HALTED);

    // ========================================================================
    // Sequencer and register updates
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_FETCH;
            pc            <= '0;
            cert_addr     <= '0;
            status        <= '0;
            error_code    <= '0;
            partition_ops <= '0;
            info_gain     <= '0;
        end else begin
            case (state)
                S_FETCH: begin
                    state <= S_DECODE;
                end
                S_DECODE: begin
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    state <= S_FETCH;
                    pc    <= next_pc;
                    case (ir.f.opcode)
                        OP_LASSERT: begin
                            state <= S_WAIT_LOGIC;
                            pc    <= pc;
                        end
                        OP_PYEXEC: begin
                            state <= S_WAIT_EXEC;
                            pc    <= pc;
                        end
                        OP_LJOIN: begin
                            cert_addr <= {ir.f.operand_a, ir.f.operand_b, 16'h0};
                            status    <= `THIELE_ST_JOIN;
                        end
                        OP_EMIT: begin
                            if (ir.f.operand_a == 8'h00) begin
                                info_gain <= {24'h0, ir.f.operand_b};
                            end else begin
                                info_gain <= info_gain + 32'd1;
                            end
                            status <= {ir.f.operand_a, ir.f.operand_b, 16'h0};
                        end
                        OP_XOR_LOAD: begin
                            if (row_ok) begin
                                status <= `THIELE_ST_LOAD;
                            end else begin
                                error_code <= `THIELE_ERR_LOAD_ROW;
                            end
                        end
                        OP_XOR_ADD: begin
                            if (row_ok) begin
                                status        <= `THIELE_ST_ADD;
                                partition_ops <= partition_ops + 32'd1;
                            end else begin
                                error_code <= `THIELE_ERR_ADD_ROW;
                            end
                        end
                        OP_XOR_SWAP: begin
                            if (row_ok) begin
                                status        <= `THIELE_ST_SWAP;
                                partition_ops <= partition_ops + 32'd1;
                            end else begin
                                error_code <= `THIELE_ERR_SWAP_ROW;
                            end
                        end
                        OP_XOR_RANK: begin
                            status <= 32'(lead_count);
                        end
                        OP_HALT: begin
                            // pc stays on the HALT word
                            state <= S_HALTED;
                            pc    <= pc;
                        end
                        default: begin
                            error_code <= `THIELE_ERR_OPCODE;
                        end
                    endcase
                end
                S_WAIT_LOGIC: begin
                    if (logic_done) begin
                        cert_addr <= logic_result;
                        pc        <= next_pc;
                        state     <= S_FETCH;
                    end
                end
                S_WAIT_EXEC: begin
                    if (exec_done) begin
                        status <= exec_result;
                        pc     <= next_pc;
                        state  <= S_FETCH;
                    end
                end
                S_HALTED: begin
                    state <= S_HALTED;
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

endmodule

// File: rtl/service_handshake.sv
`timescale 1ns/10ps

module service_handshake (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [15:0] addr,
    output logic        req,
    output logic [31:0] req_addr,
    input  logic        ack,
    input  logic [31:0] data,
    output logic        done,
    output logic [31:0] result
);

    localparam logic [1:0] HS_IDLE    = 2'd0;
    localparam logic [1:0] HS_REQUEST = 2'd1;
    localparam logic [1:0] HS_RELEASE = 2'd2;
    localparam logic [1:0] HS_FINISH  = 2'd3;

    logic [1:0] state;

    // Four-phase sequence, done only after the engine has dropped ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (start) begin
                        state <= HS_REQUEST;
                    end
                end
                HS_REQUEST: begin
                    if (ack) begin
                        state <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    if (!ack) begin
                        state <= HS_FINISH;
                    end
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    // Address latched at start, data taken when ack arrives
    always_ff @(posedge clk) begin
        if (state == HS_IDLE && start) begin
            req_addr <= {16'h0, addr};
        end
        if (state == HS_REQUEST && ack) begin
            result <= data;
        end
    end

    assign req  = (state == HS_REQUEST);
    assign done = (state == HS_FINISH);

endmodule

// File: rtl/gf2_matrix_unit.sv
`timescale 1ns/10ps

`include "thiele_cfg.svh"

module gf2_matrix_unit (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  thiele_pkg::gf2_op_t                   gf2_op,
    input  logic [$clog2(`THIELE_XOR_ROWS)-1:0]   row_a,
    input  logic [$clog2(`THIELE_XOR_ROWS)-1:0]   row_b,
    input  logic                                  row_a_ovf,
    input  logic                                  row_b_ovf,
    input  logic [`THIELE_XOR_COLS:0]             load_bits,
    output logic                                  row_ok,
    output logic [$clog2(`THIELE_XOR_ROWS):0]     lead_count
);

    import thiele_pkg::*;

    localparam int ROWS     = `THIELE_XOR_ROWS;
    localparam int ROW_BITS = `THIELE_XOR_COLS + 1;
    localparam int LC_W     = $clog2(ROWS) + 1;

    // Start pattern, bit i is column i, top bit is parity
    localparam logic [ROWS-1:0][ROW_BITS-1:0] START_PATTERN = {
        7'h03,
        7'h64,
        7'h52,
        7'h29
    };

    logic [ROW_BITS-1:0] rows [ROWS];

    // ========================================================================
    // Row index check
    // ========================================================================

    // Upper operand bits arrive folded into the two overflow flags
    always_comb begin
        case (gf2_op)
            GF2_LOAD: begin
                row_ok = !row_a_ovf;
            end
            GF2_ADD, GF2_SWAP: begin
                row_ok = !(row_a_ovf || row_b_ovf);
            end
            default: begin
                row_ok = 1'b1;
            end
        endcase
    end

    // Rows with a one in the leading column
    always_comb begin
        lead_count = '0;
        for (int r = 0; r < ROWS; r++) begin
            lead_count = lead_count + LC_W'(rows[r][0]);
        end
    end

    // ========================================================================
    // Matrix update
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= START_PATTERN[r];
            end
        end else if (row_ok) begin
            case (gf2_op)
                GF2_LOAD: begin
                    rows[row_a] <= load_bits;
                end
                GF2_ADD: begin
                    // Parity bit rides along in the XOR
                    rows[row_a] <= rows[row_a] ^ rows[row_b];
                end
                GF2_SWAP: begin
                    rows[row_a] <= rows[row_b];
                    rows[row_b] <= rows[row_a];
                end
                default: begin
                    // Count and idle leave the rows alone
                end
            endcase
        end
    end

endmodule

// File: rtl/thiele_pkg.sv
package thiele_pkg;

    // Instruction opcodes
    typedef enum logic [7:0] {
        OP_LASSERT  = 8'h03,
        OP_LJOIN    = 8'h04,
        OP_PYEXEC   = 8'h08,
        OP_XOR_LOAD = 8'h0A,
        OP_XOR_ADD  = 8'h0B,
        OP_XOR_SWAP = 8'h0C,
        OP_XOR_RANK = 8'h0D,
        OP_EMIT     = 8'h0E,
        OP_HALT     = 8'hFF
    } opcode_t;

    // Field view of an instruction word
    typedef struct packed {
        opcode_t    opcode;
        logic [7:0] operand_a;
        logic [7:0] operand_b;
        logic [7:0] spare;
    } instr_fields_t;

    // Immediate view, operand bytes joined into one address
    typedef struct packed {
        opcode_t     opcode;
        logic [15:0] imm;
        logic [7:0]  spare;
    } instr_imm_t;

    typedef union packed {
        instr_fields_t f;
        instr_imm_t    i;
    } instr_u;

    // Operations on the GF(2) matrix
    typedef enum logic [2:0] {
        GF2_NONE,
        GF2_LOAD,
        GF2_ADD,
        GF2_SWAP,
        GF2_COUNT
    } gf2_op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_WAIT_LOGIC,
        S_WAIT_EXEC,
        S_HALTED
    } ctrl_state_t;

endpackage

// File: rtl/thiele_cfg.svh
`ifndef THIELE_CFG_SVH
`define THIELE_CFG_SVH

// Matrix geometry
`define THIELE_XOR_ROWS 4
`define THIELE_XOR_COLS 6

// Byte step per instruction word
`define THIELE_PC_STEP 32'd4

// Status codes
`define THIELE_ST_JOIN 32'd4
`define THIELE_ST_LOAD 32'd7
`define THIELE_ST_ADD  32'd8
`define THIELE_ST_SWAP 32'd9

// Error codes
`define THIELE_ERR_OPCODE   32'd1
`define THIELE_ERR_ADD_ROW  32'd10
`define THIELE_ERR_SWAP_ROW 32'd11
`define THIELE_ERR_LOAD_ROW 32'd12

`endif
